//--- rtl/video_mem_pkg.sv
//******************************
// video memory package
// address split, requester order and the
// two-way word address decode
//******************************

package video_mem_pkg;

	localparam int ADDR_BITS      = 16;                     // requester word address
	localparam int DATA_BITS      = 16;                     // word width
	localparam int BYTE_BITS      = 8;
	localparam int MASK_BITS      = DATA_BITS / BYTE_BITS;  // one bit per byte lane
	localparam int NUM_BANKS      = 4;
	localparam int BANK_SEL_BITS  = $clog2(NUM_BANKS);     // top bits pick the bank
	localparam int BANK_ADDR_BITS = ADDR_BITS - BANK_SEL_BITS;  // 16K words per bank

	localparam int BOOT_ADDR_BITS = 8;                      // boot RAM is one page
	localparam int PAGE_BITS      = ADDR_BITS - BOOT_ADDR_BITS;
	localparam logic [PAGE_BITS-1:0] BOOT_PAGE = 8'h00;     // cpu page overlaid by boot RAM

	// requester index, also priority order (0 wins)
	localparam int NUM_REQ      = 6;
	localparam int REQ_IDX_BITS = $clog2(NUM_REQ);
	localparam int REQ_SPRITE   = 0;
	localparam int REQ_BG0      = 1;
	localparam int REQ_BG1      = 2;
	localparam int REQ_OV       = 3;
	localparam int REQ_FL       = 4;
	localparam int REQ_CPU      = 5;

	// one word address seen as bank/index or as page/offset
	typedef union packed {
		struct packed {
			logic [BANK_SEL_BITS-1:0]  sel;     // bank number
			logic [BANK_ADDR_BITS-1:0] index;   // word inside the bank
		} bank_v;
		struct packed {
			logic [PAGE_BITS-1:0]      page;    // 256-word page
			logic [BOOT_ADDR_BITS-1:0] offset;  // word inside the page
		} boot_v;
	} mem_addr_u;

endpackage

//--- rtl/mem_bank_if.sv
//******************************
// memory bank interface
// one bank's address, data, byte mask and
// write strobe between arbiter and RAM
//******************************

`timescale 1ns/1ps

interface mem_bank_if;

	import video_mem_pkg::*;

	logic [BANK_ADDR_BITS-1:0] addr;    // word index in bank
	logic [DATA_BITS-1:0]      din;     // write data
	logic [DATA_BITS-1:0]      dout;    // registered read data
	logic [MASK_BITS-1:0]      mask;    // byte enables, bit 1 = upper byte
	logic                      wr;      // write strobe

	modport arbiter (
		output addr,
		output din,
		output mask,
		output wr,
		input  dout
	);

	modport bank (
		input  addr,
		input  din,
		input  mask,
		input  wr,
		output dout
	);

endinterface

//--- rtl/memory_bank.sv
//******************************
// memory bank
// 16K x 16 synchronous RAM with
// byte-masked writes
//******************************

`timescale 1ns/1ps

module memory_bank (
	input logic         CLK,
	mem_bank_if.bank    bank
);

	import video_mem_pkg::*;

	localparam int DEPTH = 1 << BANK_ADDR_BITS;

	logic [DATA_BITS-1:0] mem [DEPTH];

	// banks come up cleared
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
		begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (bank.wr)
		begin
			for (int j = 0; j < MASK_BITS; j++)
			begin
				if (bank.mask[j])  // only enabled lanes
				begin
					mem[bank.addr][j*BYTE_BITS +: BYTE_BITS] <= bank.din[j*BYTE_BITS +: BYTE_BITS];
				end
			end
		end
		bank.dout <= mem[bank.addr];  // old word on read-during-write
	end

endmodule

//--- rtl/boot_memory.sv
//******************************
// boot memory
// 256 x 16 RAM overlaying cpu page 0x00
//******************************

`timescale 1ns/1ps

module boot_memory (
	input  logic                                   CLK,
	input  logic [video_mem_pkg::BOOT_ADDR_BITS-1:0] addr,
	input  logic [video_mem_pkg::DATA_BITS-1:0]      din,
	input  logic [video_mem_pkg::MASK_BITS-1:0]      mask,
	input  logic                                   wr,
	output logic [video_mem_pkg::DATA_BITS-1:0]      dout
);

	import video_mem_pkg::*;

	localparam int DEPTH = 1 << BOOT_ADDR_BITS;

	logic [DATA_BITS-1:0] mem [DEPTH];

	initial
	begin
		for (int i = 0; i < DEPTH; i++)
		begin
			mem[i] = '0;  // zero at power up
		end
	end

	always_ff @(posedge CLK)
	begin
		for (int j = 0; j < MASK_BITS; j++)
		begin
			if (wr && mask[j])
			begin
				mem[addr][j*BYTE_BITS +: BYTE_BITS] <= din[j*BYTE_BITS +: BYTE_BITS];
			end
		end
		dout <= mem[addr];  // read old word
	end

endmodule

//--- rtl/bank_arbiter.sv
//******************************
// bank arbiter
// fixed priority grant per bank, ready
// pulses and read data return
//******************************

`timescale 1ns/1ps

module bank_arbiter (
	input  logic                                CLK,
	input  logic                                reset,

	input  logic [video_mem_pkg::ADDR_BITS-1:0] sprite_addr,
	input  logic                                sprite_valid,
	output logic [video_mem_pkg::DATA_BITS-1:0] sprite_data,
	output logic                                sprite_ready,

	input  logic [video_mem_pkg::ADDR_BITS-1:0] bg0_addr,
	input  logic                                bg0_valid,
	output logic [video_mem_pkg::DATA_BITS-1:0] bg0_data,
	output logic                                bg0_ready,

	input  logic [video_mem_pkg::ADDR_BITS-1:0] bg1_addr,
	input  logic                                bg1_valid,
	output logic [video_mem_pkg::DATA_BITS-1:0] bg1_data,
	output logic                                bg1_ready,

	input  logic [video_mem_pkg::ADDR_BITS-1:0] ov_addr,
	input  logic                                ov_valid,
	output logic [video_mem_pkg::DATA_BITS-1:0] ov_data,
	output logic                                ov_ready,

	input  logic [video_mem_pkg::ADDR_BITS-1:0] fl_addr,
	input  logic [video_mem_pkg::DATA_BITS-1:0] fl_data,
	input  logic                                fl_valid,
	output logic                                fl_ready,

	input  logic [video_mem_pkg::ADDR_BITS-1:0] cpu_addr,
	input  logic [video_mem_pkg::DATA_BITS-1:0] cpu_data_in,
	input  logic                                cpu_wr,
	input  logic [video_mem_pkg::MASK_BITS-1:0] cpu_wr_mask,
	input  logic                                cpu_valid,
	output logic [video_mem_pkg::DATA_BITS-1:0] cpu_data,
	output logic                                cpu_ready,

	mem_bank_if.arbiter                         banks [video_mem_pkg::NUM_BANKS]
);

	import video_mem_pkg::*;

	mem_addr_u              req_addr  [NUM_REQ];   // request table
	logic [DATA_BITS-1:0]   req_wdata [NUM_REQ];
	logic [MASK_BITS-1:0]   req_mask  [NUM_REQ];
	logic [DATA_BITS-1:0]   req_rdata [NUM_REQ];
	logic [NUM_REQ-1:0]     req_valid;
	logic [NUM_REQ-1:0]     req_wr;
	logic [NUM_REQ-1:0]     req_ready;

	logic [NUM_BANKS-1:0]    win_vld;              // this cycle's grant
	logic [REQ_IDX_BITS-1:0] win_idx   [NUM_BANKS];
	logic [NUM_BANKS-1:0]    gnt_vld_q;            // grant taken at last edge
	logic [REQ_IDX_BITS-1:0] gnt_idx_q [NUM_BANKS];
	logic [DATA_BITS-1:0]    bank_dout [NUM_BANKS];

	// gather requesters, video ports are read only
	always_comb
	begin
		for (int r = 0; r < NUM_REQ; r++)
		begin
			req_wdata[r] = '0;
			req_mask[r]  = '0;
		end
		req_wr = '0;

		req_addr[REQ_SPRITE]  = sprite_addr;
		req_valid[REQ_SPRITE] = sprite_valid;
		req_addr[REQ_BG0]     = bg0_addr;
		req_valid[REQ_BG0]    = bg0_valid;
		req_addr[REQ_BG1]     = bg1_addr;
		req_valid[REQ_BG1]    = bg1_valid;
		req_addr[REQ_OV]      = ov_addr;
		req_valid[REQ_OV]     = ov_valid;

		req_addr[REQ_FL]      = fl_addr;
		req_valid[REQ_FL]     = fl_valid;
		req_wdata[REQ_FL]     = fl_data;
		req_mask[REQ_FL]      = '1;                 // flash writes whole words
		req_wr[REQ_FL]        = 1'b1;

		req_addr[REQ_CPU]     = cpu_addr;
		req_valid[REQ_CPU]    = cpu_valid;
		req_wdata[REQ_CPU]    = cpu_data_in;
		req_mask[REQ_CPU]     = cpu_wr ? cpu_wr_mask : '0;  // reads carry no mask
		req_wr[REQ_CPU]       = cpu_wr;
	end

	// per bank pick, scan low to high priority so the best hit lands last
	always_comb
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			win_vld[b] = 1'b0;
			win_idx[b] = '0;
			for (int r = NUM_REQ - 1; r >= 0; r--)
			begin
				if (req_valid[r] && !req_ready[r] &&
					req_addr[r].bank_v.sel == BANK_SEL_BITS'(b))  // readied ones sit out
				begin
					win_vld[b] = 1'b1;
					win_idx[b] = REQ_IDX_BITS'(r);
				end
			end
		end
	end

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank_drive
		assign banks[b].addr = req_addr[win_idx[b]].bank_v.index;
		assign banks[b].din  = req_wdata[win_idx[b]];
		assign banks[b].mask = win_vld[b] ? req_mask[win_idx[b]] : '0;
		assign banks[b].wr   = win_vld[b] & req_wr[win_idx[b]];  // idle bank never writes
		assign bank_dout[b]  = banks[b].dout;
	end

	always_ff @(posedge CLK)
	begin
		gnt_idx_q <= win_idx;
		if (reset)
		begin
			gnt_vld_q <= '0;
		end
		else
		begin
			gnt_vld_q <= win_vld;
		end
	end

	// ready and read data, one cycle after the access edge
	always_comb
	begin
		req_ready = '0;
		for (int r = 0; r < NUM_REQ; r++)
		begin
			req_rdata[r] = '0;
		end
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			if (gnt_vld_q[b])  // a requester sits in one bank only
			begin
				req_ready[gnt_idx_q[b]] = 1'b1;
				req_rdata[gnt_idx_q[b]] = bank_dout[b];
			end
		end
	end

	assign sprite_ready = req_ready[REQ_SPRITE];
	assign sprite_data  = req_rdata[REQ_SPRITE];
	assign bg0_ready    = req_ready[REQ_BG0];
	assign bg0_data     = req_rdata[REQ_BG0];
	assign bg1_ready    = req_ready[REQ_BG1];
	assign bg1_data     = req_rdata[REQ_BG1];
	assign ov_ready     = req_ready[REQ_OV];
	assign ov_data      = req_rdata[REQ_OV];
	assign fl_ready     = req_ready[REQ_FL];
	assign cpu_ready    = req_ready[REQ_CPU];
	assign cpu_data     = req_rdata[REQ_CPU];

endmodule

//--- rtl/memory_controller.sv
//******************************
// memory controller
// arbiter, four banks and the boot RAM
// overlay for cpu page 0x00
//******************************

`timescale 1ns/1ps

module memory_controller (
	input  logic                                CLK,
	input  logic                                reset,

	input  logic [video_mem_pkg::ADDR_BITS-1:0] sprite_memory_address,
	output logic [video_mem_pkg::DATA_BITS-1:0] sprite_memory_data,
	input  logic                                sprite_rvalid,   // address valid
	output logic                                sprite_rready,   // data valid

	input  logic [video_mem_pkg::ADDR_BITS-1:0] bg0_memory_address,
	output logic [video_mem_pkg::DATA_BITS-1:0] bg0_memory_data,
	input  logic                                bg0_rvalid,
	output logic                                bg0_rready,

	input  logic [video_mem_pkg::ADDR_BITS-1:0] bg1_memory_address,
	output logic [video_mem_pkg::DATA_BITS-1:0] bg1_memory_data,
	input  logic                                bg1_rvalid,
	output logic                                bg1_rready,

	input  logic [video_mem_pkg::ADDR_BITS-1:0] ov_memory_address,
	output logic [video_mem_pkg::DATA_BITS-1:0] ov_memory_data,
	input  logic                                ov_rvalid,
	output logic                                ov_rready,

	input  logic [video_mem_pkg::ADDR_BITS-1:0] fl_memory_address,
	input  logic [video_mem_pkg::DATA_BITS-1:0] fl_memory_data,
	input  logic                                fl_wvalid,       // write request
	output logic                                fl_wready,       // write done

	input  logic [video_mem_pkg::ADDR_BITS-1:0] cpu_memory_address,
	input  logic [video_mem_pkg::DATA_BITS-1:0] cpu_memory_data_in,
	output logic [video_mem_pkg::DATA_BITS-1:0] cpu_memory_data,
	input  logic                                cpu_valid,
	input  logic                                cpu_wr,          // cpu writing
	output logic                                cpu_ready,       // access done
	input  logic [video_mem_pkg::MASK_BITS-1:0] cpu_wr_mask      // byte lanes to write
);

	import video_mem_pkg::*;

	mem_addr_u            cpu_addr_u;
	logic                 boot_hit;       // cpu address in boot page
	logic                 boot_access;    // boot RAM takes it at next edge
	logic                 boot_ready_q;
	logic [PAGE_BITS-1:0] cpu_page_q;     // page of the access just done
	logic [DATA_BITS-1:0] boot_dout;
	logic [DATA_BITS-1:0] arb_cpu_data;
	logic                 arb_cpu_ready;

	mem_bank_if bank_if [NUM_BANKS] ();

	assign cpu_addr_u  = cpu_memory_address;
	assign boot_hit    = (cpu_addr_u.boot_v.page == BOOT_PAGE);
	assign boot_access = cpu_valid & boot_hit & ~boot_ready_q;  // one access per two cycles

	always_ff @(posedge CLK)
	begin
		cpu_page_q <= cpu_addr_u.boot_v.page;
		if (reset)
		begin
			boot_ready_q <= 1'b0;
		end
		else
		begin
			boot_ready_q <= boot_access;
		end
	end

	boot_memory u_boot (
		.CLK  (CLK),
		.addr (cpu_addr_u.boot_v.offset),
		.din  (cpu_memory_data_in),
		.mask (cpu_wr_mask),
		.wr   (boot_access & cpu_wr),
		.dout (boot_dout)
	);

	bank_arbiter u_arbiter (
		.CLK          (CLK),
		.reset        (reset),
		.sprite_addr  (sprite_memory_address),
		.sprite_valid (sprite_rvalid),
		.sprite_data  (sprite_memory_data),
		.sprite_ready (sprite_rready),
		.bg0_addr     (bg0_memory_address),
		.bg0_valid    (bg0_rvalid),
		.bg0_data     (bg0_memory_data),
		.bg0_ready    (bg0_rready),
		.bg1_addr     (bg1_memory_address),
		.bg1_valid    (bg1_rvalid),
		.bg1_data     (bg1_memory_data),
		.bg1_ready    (bg1_rready),
		.ov_addr      (ov_memory_address),
		.ov_valid     (ov_rvalid),
		.ov_data      (ov_memory_data),
		.ov_ready     (ov_rready),
		.fl_addr      (fl_memory_address),
		.fl_data      (fl_memory_data),
		.fl_valid     (fl_wvalid),
		.fl_ready     (fl_wready),
		.cpu_addr     (cpu_memory_address),
		.cpu_data_in  (cpu_memory_data_in),
		.cpu_wr       (cpu_wr),
		.cpu_wr_mask  (cpu_wr_mask),
		.cpu_valid    (cpu_valid & ~boot_hit),  // boot page stays off the banks
		.cpu_data     (arb_cpu_data),
		.cpu_ready    (arb_cpu_ready),
		.banks        (bank_if)
	);

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		memory_bank u_bank (
			.CLK  (CLK),
			.bank (bank_if[b])
		);
	end

	// overlay select on the page registered at the access edge
	assign cpu_memory_data = (cpu_page_q == BOOT_PAGE) ? boot_dout : arb_cpu_data;
	assign cpu_ready       = boot_ready_q | arb_cpu_ready;  // never both high

endmodule

//--- testbench/tb_clock_gen.sv
//******************************
// clock and reset source
// 10 ns clock, reset for five cycles
//******************************

`timescale 1ns/1ps

module tb_clock_gen (
	output logic CLK,
	output logic reset
);

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;  // 100 MHz
	end

	initial
	begin
		reset = 1'b1;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;  // release away from the active edge
	end

endmodule

//--- testbench/memory_controller_asserts.sv
//******************************
// memory controller checker
// shadow memories, ready timing,
// priority and read data assertions
//******************************

`timescale 1ns/1ps

module memory_controller_asserts (
	input logic                                CLK,
	input logic                                reset,
	input logic [video_mem_pkg::ADDR_BITS-1:0] sprite_memory_address,
	input logic [video_mem_pkg::DATA_BITS-1:0] sprite_memory_data,
	input logic                                sprite_rvalid,
	input logic                                sprite_rready,
	input logic [video_mem_pkg::ADDR_BITS-1:0] bg0_memory_address,
	input logic [video_mem_pkg::DATA_BITS-1:0] bg0_memory_data,
	input logic                                bg0_rvalid,
	input logic                                bg0_rready,
	input logic [video_mem_pkg::ADDR_BITS-1:0] bg1_memory_address,
	input logic [video_mem_pkg::DATA_BITS-1:0] bg1_memory_data,
	input logic                                bg1_rvalid,
	input logic                                bg1_rready,
	input logic [video_mem_pkg::ADDR_BITS-1:0] ov_memory_address,
	input logic [video_mem_pkg::DATA_BITS-1:0] ov_memory_data,
	input logic                                ov_rvalid,
	input logic                                ov_rready,
	input logic [video_mem_pkg::ADDR_BITS-1:0] fl_memory_address,
	input logic [video_mem_pkg::DATA_BITS-1:0] fl_memory_data,
	input logic                                fl_wvalid,
	input logic                                fl_wready,
	input logic [video_mem_pkg::ADDR_BITS-1:0] cpu_memory_address,
	input logic [video_mem_pkg::DATA_BITS-1:0] cpu_memory_data_in,
	input logic [video_mem_pkg::DATA_BITS-1:0] cpu_memory_data,
	input logic                                cpu_valid,
	input logic                                cpu_wr,
	input logic                                cpu_ready,
	input logic [video_mem_pkg::MASK_BITS-1:0] cpu_wr_mask
);

	import video_mem_pkg::*;

	logic [15:0] shadow [65536];   // whole address space
	logic [15:0] boot_shadow [256];
	logic [15:0] vaddr [6];
	logic [15:0] addr_q [6];       // addresses held at the access edge
	logic [15:0] fl_data_q;
	logic [15:0] cpu_din_q;
	logic [1:0]  cpu_mask_q;
	logic        cpu_wr_q;
	logic        cpu_boot_q;       // last access went to boot RAM
	logic [5:0]  vld;              // valid as the arbiter sees it
	logic [5:0]  rdy;
	logic [5:0]  blocked;          // a higher priority one waits on our bank
	logic        cpu_boot;
	logic [15:0] exp_cpu;

	initial
	begin
		for (int i = 0; i < 65536; i++)
		begin
			shadow[i] = '0;
		end
		for (int i = 0; i < 256; i++)
		begin
			boot_shadow[i] = '0;
		end
	end

	assign cpu_boot = (cpu_memory_address[15:8] == 8'h00);
	assign vaddr[0] = sprite_memory_address;
	assign vaddr[1] = bg0_memory_address;
	assign vaddr[2] = bg1_memory_address;
	assign vaddr[3] = ov_memory_address;
	assign vaddr[4] = fl_memory_address;
	assign vaddr[5] = cpu_memory_address;
	assign vld = {cpu_valid & ~cpu_boot, fl_wvalid, ov_rvalid,
		bg1_rvalid, bg0_rvalid, sprite_rvalid};
	assign rdy = {cpu_ready, fl_wready, ov_rready, bg1_rready, bg0_rready, sprite_rready};
	assign exp_cpu = cpu_boot_q ? boot_shadow[addr_q[5][7:0]] : shadow[addr_q[5]];

	always_comb
	begin
		blocked = '0;
		for (int r = 1; r < 6; r++)
		begin
			for (int h = 0; h < r; h++)
			begin
				if (vld[r] && vld[h] && !rdy[h] &&
					vaddr[h][15:14] == vaddr[r][15:14])  // same bank
				begin
					blocked[r] = 1'b1;
				end
			end
		end
	end

	// requests may move on in their ready cycle
	always_ff @(posedge CLK)
	begin
		addr_q     <= vaddr;
		fl_data_q  <= fl_memory_data;
		cpu_din_q  <= cpu_memory_data_in;
		cpu_mask_q <= cpu_wr_mask;
		cpu_wr_q   <= cpu_wr;
		cpu_boot_q <= cpu_boot;
	end

	// writes land in the shadow at their ready
	always_ff @(posedge CLK)
	begin
		if (!reset)
		begin
			if (fl_wready)
			begin
				shadow[addr_q[4]] <= fl_data_q;
			end
			if (cpu_ready && cpu_wr_q)
			begin
				for (int j = 0; j < 2; j++)
				begin
					if (cpu_mask_q[j] && cpu_boot_q)
					begin
						boot_shadow[addr_q[5][7:0]][j*8 +: 8] <= cpu_din_q[j*8 +: 8];
					end
					else if (cpu_mask_q[j])
					begin
						shadow[addr_q[5]][j*8 +: 8] <= cpu_din_q[j*8 +: 8];
					end
				end
			end
		end
	end

	a_reset_quiet: assert property (@(posedge CLK) reset |=> rdy == '0)
		else $error("ready seen during or right after reset");
	a_ready_held: assert property (@(posedge CLK) disable iff (reset)
		(rdy & ~$past(vld | {cpu_valid, 5'b0})) == '0)
		else $error("ready without a held valid");
	a_priority: assert property (@(posedge CLK) disable iff (reset) (rdy & $past(blocked)) == '0)
		else $error("ready given past a waiting higher priority requester");
	a_sprite_lat: assert property (@(posedge CLK) disable iff (reset)
		$rose(sprite_rvalid) |=> sprite_rready)
		else $error("sprite latency not one cycle");
	a_fl_lat: assert property (@(posedge CLK) disable iff (reset)
		($rose(fl_wvalid) && !blocked[4]) |=> fl_wready)
		else $error("lone flash write latency not one cycle");
	a_sprite_data: assert property (@(posedge CLK) disable iff (reset)
		sprite_rready |-> sprite_memory_data == shadow[addr_q[0]]) else $error("sprite data");
	a_bg0_data: assert property (@(posedge CLK) disable iff (reset)
		bg0_rready |-> bg0_memory_data == shadow[addr_q[1]]) else $error("bg0 data");
	a_bg1_data: assert property (@(posedge CLK) disable iff (reset)
		bg1_rready |-> bg1_memory_data == shadow[addr_q[2]]) else $error("bg1 data");
	a_ov_data: assert property (@(posedge CLK) disable iff (reset)
		ov_rready |-> ov_memory_data == shadow[addr_q[3]]) else $error("ov data");
	a_cpu_data: assert property (@(posedge CLK) disable iff (reset)
		(cpu_ready && !cpu_wr_q) |-> cpu_memory_data == exp_cpu) else $error("cpu data");

endmodule

//--- testbench/tb_memory_controller.sv
//******************************
// memory controller testbench
// directed timing, mask and overlay tests
// then six-way random contention
//******************************

`timescale 1ns/1ps

module tb_memory_controller;

	localparam int TEST_CYCLES = 5 + 40 * 6 + 300 + 200;  // reset, directed, random, drain

	logic        CLK;
	logic        reset;
	logic [15:0] vid_addr [4];   // sprite, bg0, bg1, ov
	logic        vid_valid [4];
	logic [15:0] vid_data [4];
	logic        vid_ready [4];
	logic [15:0] fl_addr;
	logic [15:0] fl_data;
	logic        fl_valid;
	logic        fl_ready;
	logic [15:0] cpu_addr;
	logic [15:0] cpu_din;
	logic [15:0] cpu_dout;
	logic        cpu_valid;
	logic        cpu_wr;
	logic        cpu_ready;
	logic [1:0]  cpu_mask;
	integer      seed;
	int          data_errors;
	int          other_errors;
	int          par_count;      // cycles with readies on several banks

	tb_clock_gen u_clk (.CLK(CLK), .reset(reset));

	memory_controller u_dut (
		.CLK(CLK), .reset(reset),
		.sprite_memory_address(vid_addr[0]), .sprite_memory_data(vid_data[0]),
		.sprite_rvalid(vid_valid[0]), .sprite_rready(vid_ready[0]),
		.bg0_memory_address(vid_addr[1]), .bg0_memory_data(vid_data[1]),
		.bg0_rvalid(vid_valid[1]), .bg0_rready(vid_ready[1]),
		.bg1_memory_address(vid_addr[2]), .bg1_memory_data(vid_data[2]),
		.bg1_rvalid(vid_valid[2]), .bg1_rready(vid_ready[2]),
		.ov_memory_address(vid_addr[3]), .ov_memory_data(vid_data[3]),
		.ov_rvalid(vid_valid[3]), .ov_rready(vid_ready[3]),
		.fl_memory_address(fl_addr), .fl_memory_data(fl_data),
		.fl_wvalid(fl_valid), .fl_wready(fl_ready),
		.cpu_memory_address(cpu_addr), .cpu_memory_data_in(cpu_din),
		.cpu_memory_data(cpu_dout), .cpu_valid(cpu_valid), .cpu_wr(cpu_wr),
		.cpu_ready(cpu_ready), .cpu_wr_mask(cpu_mask)
	);

	bind memory_controller memory_controller_asserts u_asserts (.*);

	function automatic logic [15:0] merge_bytes(logic [15:0] old_w, logic [15:0] new_w,
		logic [1:0] mask);
		logic [15:0] res;
		res = old_w;
		if (mask[0]) res[7:0] = new_w[7:0];     // lower byte
		if (mask[1]) res[15:8] = new_w[15:8];
		return res;
	endfunction

	// small window so requesters collide, bank 0 also reaches page 0x00
	function automatic logic [15:0] pick_addr();
		logic [31:0] r;
		r = $random(seed);
		return {r[1:0], 5'b0, r[2], 4'b0, r[6:3]};
	endfunction

	task automatic check_word(string name, logic [15:0] got, logic [15:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			data_errors++;
		end
	endtask

	task automatic check_latency(string name, int cycles);
		if (cycles != 1)
		begin
			$display("%s took %0d cycles instead of one", name, cycles);
			other_errors++;
		end
	endtask

	task automatic fl_write(logic [15:0] addr, logic [15:0] data, output int cycles);
		@(negedge CLK);
		fl_addr = addr;
		fl_data = data;
		fl_valid = 1'b1;
		cycles = 0;
		do
		begin
			@(negedge CLK);
			cycles++;
		end
		while (!fl_ready && cycles < 100);
		if (!fl_ready)
		begin
			$display("flash write never got ready");
			other_errors++;
		end
		fl_valid = 1'b0;
	endtask

	task automatic video_read(int port, logic [15:0] addr, output logic [15:0] data,
		output int cycles);
		@(negedge CLK);
		vid_addr[port] = addr;
		vid_valid[port] = 1'b1;
		cycles = 0;
		do
		begin
			@(negedge CLK);
			cycles++;
		end
		while (!vid_ready[port] && cycles < 100);
		if (!vid_ready[port])
		begin
			$display("video read never got ready");
			other_errors++;
		end
		data = vid_data[port];  // only valid in the ready cycle
		vid_valid[port] = 1'b0;
	endtask

	task automatic cpu_access(logic wr, logic [1:0] mask, logic [15:0] addr,
		logic [15:0] din, output logic [15:0] data, output int cycles);
		@(negedge CLK);
		cpu_addr = addr;
		cpu_din = din;
		cpu_wr = wr;
		cpu_mask = mask;
		cpu_valid = 1'b1;
		cycles = 0;
		do
		begin
			@(negedge CLK);
			cycles++;
		end
		while (!cpu_ready && cycles < 100);
		if (!cpu_ready)
		begin
			$display("cpu access never got ready");
			other_errors++;
		end
		data = cpu_dout;
		cpu_valid = 1'b0;
	endtask

	// random traffic on all six ports, new request only after ready
	task automatic random_traffic(int n);
		logic [31:0] r;
		for (int c = 0; c < n; c++)
		begin
			@(negedge CLK);
			for (int p = 0; p < 4; p++)
			begin
				if (!vid_valid[p] || vid_ready[p])
				begin
					r = $random(seed);
					vid_valid[p] = r[0] & (c < n - 1);
					vid_addr[p] = pick_addr();
				end
			end
			if (!fl_valid || fl_ready)
			begin
				r = $random(seed);
				fl_valid = r[0] & (c < n - 1);
				fl_addr = pick_addr();
				fl_data = r[31:16];
			end
			if (!cpu_valid || cpu_ready)
			begin
				r = $random(seed);
				cpu_valid = r[0] & (c < n - 1);
				cpu_wr = r[1];
				cpu_mask = r[3:2];
				cpu_din = r[31:16];
				cpu_addr = pick_addr();
			end
		end
	endtask

	// let held requests finish, then drop them
	task automatic drain();
		int c;
		c = 0;
		while ((vid_valid[0] || vid_valid[1] || vid_valid[2] || vid_valid[3] ||
			fl_valid || cpu_valid) && c < 200)
		begin
			@(negedge CLK);
			for (int p = 0; p < 4; p++)
			begin
				if (vid_ready[p]) vid_valid[p] = 1'b0;
			end
			if (fl_ready) fl_valid = 1'b0;
			if (cpu_ready) cpu_valid = 1'b0;
			c++;
		end
		if (c >= 200)
		begin
			$display("requests still pending after drain");
			other_errors++;
		end
	endtask

	always @(negedge CLK)
	begin
		if (!reset && (vid_ready[0] + vid_ready[1] + vid_ready[2] + vid_ready[3] +
			fl_ready + cpu_ready) >= 2)
		begin
			par_count++;
		end
	end

	initial
	begin
		#(TEST_CYCLES * 10 * 4 + 1000);
		$display("watchdog expired, the run did not finish");
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		logic [15:0] rd;
		logic [15:0] expw;
		int          cyc;
		string       vid_name [4];
		vid_name = '{"sprite_memory_data", "bg0_memory_data",
			"bg1_memory_data", "ov_memory_data"};
		seed = 78;
		data_errors = 0;
		other_errors = 0;
		par_count = 0;
		for (int p = 0; p < 4; p++)
		begin
			vid_addr[p] = '0;
			vid_valid[p] = 1'b0;
		end
		fl_addr = '0;
		fl_data = '0;
		fl_valid = 1'b0;
		cpu_addr = '0;
		cpu_din = '0;
		cpu_valid = 1'b0;
		cpu_wr = 1'b0;
		cpu_mask = '0;
		@(negedge CLK);
		while (reset) @(negedge CLK);

		fl_write(16'h4123, 16'hA5C3, cyc);  // bank 1, alone
		check_latency("flash write", cyc);
		for (int p = 0; p < 4; p++)
		begin
			video_read(p, 16'h4123, rd, cyc);
			check_word(vid_name[p], rd, 16'hA5C3);
			check_latency(vid_name[p], cyc);
		end

		expw = merge_bytes(16'h0000, 16'h1234, 2'b11);
		cpu_access(1'b1, 2'b11, 16'h8210, 16'h1234, rd, cyc);
		cpu_access(1'b0, 2'b00, 16'h8210, 16'h0000, rd, cyc);
		check_word("cpu_memory_data", rd, expw);
		expw = merge_bytes(expw, 16'hABCD, 2'b01);
		cpu_access(1'b1, 2'b01, 16'h8210, 16'hABCD, rd, cyc);
		cpu_access(1'b0, 2'b00, 16'h8210, 16'h0000, rd, cyc);
		check_word("cpu_memory_data", rd, expw);
		expw = merge_bytes(expw, 16'h5E77, 2'b10);
		cpu_access(1'b1, 2'b10, 16'h8210, 16'h5E77, rd, cyc);
		cpu_access(1'b0, 2'b00, 16'h8210, 16'h0000, rd, cyc);
		check_word("cpu_memory_data", rd, expw);

		// boot page overlay against bank 0
		cpu_access(1'b1, 2'b11, 16'h0042, 16'hBEEF, rd, cyc);
		check_latency("boot write", cyc);
		fl_write(16'h0042, 16'h7777, cyc);
		cpu_access(1'b0, 2'b00, 16'h0042, 16'h0000, rd, cyc);
		check_word("cpu_memory_data", rd, 16'hBEEF);
		video_read(0, 16'h0042, rd, cyc);
		check_word("sprite_memory_data", rd, 16'h7777);
		fl_write(16'h0142, 16'h3C3C, cyc);
		cpu_access(1'b0, 2'b00, 16'h0142, 16'h0000, rd, cyc);
		check_word("cpu_memory_data", rd, 16'h3C3C);

		par_count = 0;
		random_traffic(300);
		drain();
		if (par_count == 0)
		begin
			$display("no cycle had readies on different banks at once");
			other_errors++;
		end

		repeat (3) @(negedge CLK);
		$display("closing: %0d data errors, %0d other errors, %0d parallel ready cycles",
			data_errors, other_errors, par_count);
		if (data_errors == 0 && other_errors == 0)
		begin
			$display("=== PASS ===");
		end
		else
		begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- memory_controller.f
rtl/video_mem_pkg.sv
rtl/mem_bank_if.sv
rtl/memory_bank.sv
rtl/boot_memory.sv
rtl/bank_arbiter.sv
rtl/memory_controller.sv
testbench/tb_clock_gen.sv
testbench/memory_controller_asserts.sv
testbench/tb_memory_controller.sv

//--- sim.sh
#!/bin/sh
# build and run the memory controller testbench with Verilator

rm -f sim.log

verilator --binary --timing --assert \
	-f memory_controller.f \
	--top-module tb_memory_controller \
	-o tb_memory_controller > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_memory_controller 2>&1 | tee sim.log

grep -q "=== PASS ===" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
